// File: verilog/vga_settings.svh
`ifndef VGA_SETTINGS_SVH
`define VGA_SETTINGS_SVH

// ---------------------------------------------------------------------------
// raster geometry, 640x480 at the pixel clock
// ---------------------------------------------------------------------------
`define H_TOTAL         800
`define V_TOTAL         521
`define H_PULSE         96
`define V_PULSE         2
`define H_ACTIVE_START  144
`define H_ACTIVE_END    784
`define V_ACTIVE_START  31
`define V_ACTIVE_END    511
`define SCREEN_LINES    480

// sprite half sizes, in pixels from the centre
`define PLAYER_HALF     9
`define ENEMY_HALF      7
`define ENEMY_SHOT_HALF 3
`define SHOT_HALF_W     1
`define SHOT_HALF_H     5

// enemy formation, first four on row 0, last three on row 1
`define ENEMY_COUNT     7
`define ENEMY_ROW0_Y    420
`define ENEMY_ROW1_Y    360
`define ENEMY_X0        128
`define ENEMY_X1        256
`define ENEMY_X2        384
`define ENEMY_X3        512
`define ENEMY_X4        160
`define ENEMY_X5        320
`define ENEMY_X6        480

// colours as {r[2:0], g[2:0], b[1:0]}
`define COL_ENEMY       {3'd7, 3'd0, 2'd3}
`define COL_ENEMY_SHOT  {3'd7, 3'd0, 2'd0}
`define COL_SHOT        {3'd0, 3'd0, 2'd3}
`define COL_PLAYER      {3'd2, 3'd2, 2'd2}

`endif

// File: verilog/vga_pkg.sv
`default_nettype none

package vga_pkg;

	// free running counts, pixel and line
	typedef struct packed {
		logic [9:0] h;
		logic [9:0] v;
	} raster_pos_t;

	// position inside the visible window
	typedef struct packed {
		logic [9:0] col;
		logic [9:0] row;
		logic       active;
	} screen_pos_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} rgb_t;

	// both active low
	typedef struct packed {
		logic hsync;
		logic vsync;
	} sync_t;

endpackage

`default_nettype wire

// File: verilog/game_pkg.sv
`default_nettype none

`include "vga_settings.svh"

package game_pkg;

	// ------------------------------------------------------------------------
	// game coordinates
	// ------------------------------------------------------------------------
	// x runs left to right like the screen column
	typedef logic [9:0] game_x_t;

	// y counts up from the bottom edge, screen row is 480 - y
	typedef logic [8:0] game_y_t;

	// ------------------------------------------------------------------------
	// scene snapshot, one per frame
	// ------------------------------------------------------------------------
	typedef struct packed {
		game_x_t                          player_x;
		game_y_t                          player_y;
		game_x_t                          shot_x;
		game_y_t                          shot_y;
		logic [`ENEMY_COUNT-1:0]          enemy_alive;
		// shots fall along the column of their enemy
		game_y_t [`ENEMY_COUNT-1:0]       enemy_shot_y;
	} scene_t;

	// per pixel object coverage, before priority
	typedef struct packed {
		logic enemy;
		logic shot;
		logic enemy_shot;
		logic player;
	} layer_hits_t;

endpackage

`default_nettype wire

// File: verilog/raster_timing.sv
`timescale 1ns/100ps
`default_nettype none

`include "vga_settings.svh"

module raster_timing import vga_pkg::*; (
	input  wire         dclk,
	input  wire         clr,
	output screen_pos_t pos,
	output sync_t       raw_sync,
	output logic        frame_end
);

	raster_pos_t cnt;
	logic        h_last;
	logic        v_last;

	assign h_last = (cnt.h == 10'(`H_TOTAL - 1));
	assign v_last = (cnt.v == 10'(`V_TOTAL - 1));

	// pixel counter wraps each line, line counter each frame
	always_ff @(posedge dclk or posedge clr) begin
		if (clr) begin
			cnt <= '0;
		end else if (h_last) begin
			cnt.h <= '0;
			cnt.v <= v_last ? '0 : cnt.v + 10'd1;
		end else begin
			cnt.h <= cnt.h + 10'd1;
		end
	end

	assign frame_end = h_last && v_last;

	// pulses sit at the start of the line and of the frame
	assign raw_sync.hsync = (cnt.h >= 10'(`H_PULSE));
	assign raw_sync.vsync = (cnt.v >= 10'(`V_PULSE));

	// ---------------------------------------------------------------------------
	// visible window
	// ---------------------------------------------------------------------------
	assign pos.col    = cnt.h - 10'(`H_ACTIVE_START);
	assign pos.row    = cnt.v - 10'(`V_ACTIVE_START);
	assign pos.active = (cnt.h >= 10'(`H_ACTIVE_START)) &&
		(cnt.h < 10'(`H_ACTIVE_END)) &&
		(cnt.v >= 10'(`V_ACTIVE_START)) &&
		(cnt.v < 10'(`V_ACTIVE_END));

endmodule

`default_nettype wire

// File: verilog/object_hit.sv
`timescale 1ns/100ps
`default_nettype none

`include "vga_settings.svh"

module object_hit import vga_pkg::*, game_pkg::*; (
	input  wire         dclk,
	input  wire         clr,
	input  wire         frame_end,
	input  wire scene_t scene,
	input  wire screen_pos_t pos,
	output layer_hits_t hits
);

	// ---------------------------------------------------------------------------
	// fixed enemy formation
	// ---------------------------------------------------------------------------
	localparam int ENEMY_X [`ENEMY_COUNT] = '{
		`ENEMY_X0, `ENEMY_X1, `ENEMY_X2, `ENEMY_X3,
		`ENEMY_X4, `ENEMY_X5, `ENEMY_X6
	};
	localparam int ENEMY_Y [`ENEMY_COUNT] = '{
		`ENEMY_ROW0_Y, `ENEMY_ROW0_Y, `ENEMY_ROW0_Y, `ENEMY_ROW0_Y,
		`ENEMY_ROW1_Y, `ENEMY_ROW1_Y, `ENEMY_ROW1_Y
	};

	scene_t                  scene_q;
	logic [`ENEMY_COUNT-1:0] enemy_in;
	logic [`ENEMY_COUNT-1:0] enemy_shot_in;
	logic                    shot_in;
	logic                    player_in;

	// inclusive box test around (cx, 480 - cy), signed so that
	// objects hanging off an edge still clip correctly
	function automatic logic in_box(
		input int col,
		input int row,
		input int cx,
		input int cy,
		input int half_w,
		input int half_h
	);
		int cr;
		cr = `SCREEN_LINES - cy;
		return (col >= cx - half_w) && (col <= cx + half_w) &&
			(row >= cr - half_h) && (row <= cr + half_h);
	endfunction

	// ---------------------------------------------------------------------------
	// scene snapshot
	// ---------------------------------------------------------------------------
	// taken in the last pixel of the frame, so it governs the
	// whole of the next one
	always_ff @(posedge dclk or posedge clr) begin
		if (clr) begin
			scene_q <= '0;
		end else if (frame_end) begin
			scene_q <= scene;
		end
	end

	// ---------------------------------------------------------------------------
	// per object coverage
	// ---------------------------------------------------------------------------
	always_comb begin
		for (int i = 0; i < `ENEMY_COUNT; i++) begin
			enemy_in[i] = scene_q.enemy_alive[i] &&
				in_box(pos.col, pos.row, ENEMY_X[i], ENEMY_Y[i],
					`ENEMY_HALF, `ENEMY_HALF);
		end
	end

	// shots keep falling after their enemy is gone
	always_comb begin
		for (int i = 0; i < `ENEMY_COUNT; i++) begin
			enemy_shot_in[i] = in_box(pos.col, pos.row, ENEMY_X[i],
				int'(scene_q.enemy_shot_y[i]),
				`ENEMY_SHOT_HALF, `ENEMY_SHOT_HALF);
		end
	end

	assign shot_in = in_box(pos.col, pos.row,
		int'(scene_q.shot_x), int'(scene_q.shot_y),
		`SHOT_HALF_W, `SHOT_HALF_H);

	assign player_in = in_box(pos.col, pos.row,
		int'(scene_q.player_x), int'(scene_q.player_y),
		`PLAYER_HALF, `PLAYER_HALF);

	// collapse into one bit per layer
	assign hits.enemy      = |enemy_in;
	assign hits.enemy_shot = |enemy_shot_in;
	assign hits.shot       = shot_in;
	assign hits.player     = player_in;

endmodule

`default_nettype wire

// File: verilog/pixel_out.sv
`timescale 1ns/100ps
`default_nettype none

`include "vga_settings.svh"

module pixel_out import vga_pkg::*, game_pkg::*; (
	input  wire              dclk,
	input  wire              clr,
	input  wire              pos_active,
	input  wire layer_hits_t hits,
	input  wire sync_t       raw_sync,
	output rgb_t             rgb,
	output sync_t            sync
);

	rgb_t colour;

	// top layer first, blanking wins over everything
	always_comb begin
		if (!pos_active) begin
			colour = '0;
		end else if (hits.player) begin
			colour = `COL_PLAYER;
		end else if (hits.enemy_shot) begin
			colour = `COL_ENEMY_SHOT;
		end else if (hits.shot) begin
			colour = `COL_SHOT;
		end else if (hits.enemy) begin
			colour = `COL_ENEMY;
		end else begin
			colour = '0;
		end
	end

	// colour and sync share one register stage so they stay aligned
	always_ff @(posedge dclk or posedge clr) begin
		if (clr) begin
			rgb  <= '0;
			sync <= '1;
		end else begin
			rgb  <= colour;
			sync <= raw_sync;
		end
	end

endmodule

`default_nettype wire

// File: verilog/shooter_display.sv
`timescale 1ns/100ps
`default_nettype none

module shooter_display import vga_pkg::*, game_pkg::*; (
	input  wire         dclk,
	input  wire         clr,
	input  wire scene_t scene,
	output sync_t       sync,
	output rgb_t        rgb
);

	screen_pos_t pos;
	sync_t       raw_sync;
	logic        frame_end;
	layer_hits_t hits;

	raster_timing i_raster_timing (
		.dclk      (dclk),
		.clr       (clr),
		.pos       (pos),
		.raw_sync  (raw_sync),
		.frame_end (frame_end)
	);

	object_hit i_object_hit (
		.dclk      (dclk),
		.clr       (clr),
		.frame_end (frame_end),
		.scene     (scene),
		.pos       (pos),
		.hits      (hits)
	);

	// one register stage to the pins
	pixel_out i_pixel_out (
		.dclk       (dclk),
		.clr        (clr),
		.pos_active (pos.active),
		.hits       (hits),
		.raw_sync   (raw_sync),
		.rgb        (rgb),
		.sync       (sync)
	);

endmodule

`default_nettype wire

// File: dv/tb_shooter_display.sv
`timescale 1ns/100ps
`default_nettype none

`include "vga_settings.svh"

module tb_shooter_display import vga_pkg::*, game_pkg::*; ();

	localparam int    FRAMES_IN_TESTS = 10;
	localparam longint WATCHDOG_NS =
		longint'(FRAMES_IN_TESTS) * `H_TOTAL * `V_TOTAL * 8 * 11 / 10;
	localparam int    ENEMY_X [`ENEMY_COUNT] = '{`ENEMY_X0, `ENEMY_X1, `ENEMY_X2, `ENEMY_X3,
		`ENEMY_X4, `ENEMY_X5, `ENEMY_X6};

	logic        dclk;
	logic        clr;
	scene_t      scene;
	sync_t       sync;
	rgb_t        rgb;
	scene_t      held;
	scene_t      s;
	int          seed;
	int          h;
	int          v;
	logic        locked;
	logic        prev_hs;
	int          hs_low, vs_low, lines;
	int          last_hs_low, last_vs_low, last_lines;
	int          checks, errors, test_base;
	event        frame_start;

	shooter_display i_shooter_display (
		.dclk  (dclk),
		.clr   (clr),
		.scene (scene),
		.sync  (sync),
		.rgb   (rgb)
	);

	always #4 dclk = ~dclk;

	// ------------------------------------------------------------------------
	// expected picture
	// ------------------------------------------------------------------------
	// inclusive rectangle around (cx, 480 - cy)
	function automatic logic covers(int col, int row, int cx, int cy, int hw, int hh);
		int dx;
		int dy;
		dx = col - cx;
		dy = row - (`SCREEN_LINES - cy);
		if (dx < 0) dx = -dx;
		if (dy < 0) dy = -dy;
		return (dx <= hw) && (dy <= hh);
	endfunction

	function automatic rgb_t expected_pixel(scene_t sc, int hp, int vp);
		int   col;
		int   row;
		int   ey;
		logic en;
		logic es;
		if (hp < `H_ACTIVE_START || hp >= `H_ACTIVE_END ||
			vp < `V_ACTIVE_START || vp >= `V_ACTIVE_END) return '0;
		col = hp - `H_ACTIVE_START;
		row = vp - `V_ACTIVE_START;
		en = 1'b0;
		es = 1'b0;
		for (int i = 0; i < `ENEMY_COUNT; i++) begin
			ey = (i < 4) ? `ENEMY_ROW0_Y : `ENEMY_ROW1_Y;
			if (sc.enemy_alive[i] &&
				covers(col, row, ENEMY_X[i], ey, `ENEMY_HALF, `ENEMY_HALF)) en = 1'b1;
			if (covers(col, row, ENEMY_X[i], sc.enemy_shot_y[i],
				`ENEMY_SHOT_HALF, `ENEMY_SHOT_HALF)) es = 1'b1;
		end
		// player, enemy shot, player shot, enemy
		if (covers(col, row, sc.player_x, sc.player_y, `PLAYER_HALF, `PLAYER_HALF))
			return `COL_PLAYER;
		if (es) return `COL_ENEMY_SHOT;
		if (covers(col, row, sc.shot_x, sc.shot_y, `SHOT_HALF_W, `SHOT_HALF_H))
			return `COL_SHOT;
		if (en) return `COL_ENEMY;
		return '0;
	endfunction

	// both pulses low during the first pixels of a line or lines of a frame
	function automatic sync_t expected_sync(int hp, int vp);
		sync_t sy;
		sy.hsync = !(hp < `H_PULSE);
		sy.vsync = !(vp < `V_PULSE);
		return sy;
	endfunction

	task automatic check_rgb(input rgb_t got, input rgb_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			if (errors <= 25)
				$display("MISMATCH rgb: got %h expected %h at h %0d v %0d, %0t",
					got, exp, h, v, $time);
		end
	endtask

	task automatic check_sync(input sync_t got, input sync_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			if (errors <= 25)
				$display("MISMATCH sync: got %h expected %h at h %0d v %0d, %0t",
					got, exp, h, v, $time);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("%s counted %0d times in a frame instead of %0d", what, got, exp);
		end
	endtask

	// ------------------------------------------------------------------------
	// raster follower and compare
	// ------------------------------------------------------------------------
	// locks on the first pixel with both syncs low and free runs after that
	always @(negedge dclk) begin
		if (locked) begin
			h++;
			if (h == `H_TOTAL) begin
				h = 0;
				v = (v == `V_TOTAL - 1) ? 0 : v + 1;
			end
		end else if (!clr && !sync.hsync && !sync.vsync) begin
			locked = 1'b1;
			h = 0;
			v = 0;
		end
		if (locked) begin
			if (h == 0 && v == 0) begin
				held = scene;
				last_hs_low = hs_low;
				last_vs_low = vs_low;
				last_lines = lines;
				hs_low = 0;
				vs_low = 0;
				lines = 0;
			end
			hs_low += !sync.hsync;
			vs_low += !sync.vsync;
			lines += prev_hs && !sync.hsync;
			check_sync(sync, expected_sync(h, v));
			check_rgb(rgb, expected_pixel(held, h, v));
			if (h == 0 && v == 0) -> frame_start;
		end
		prev_hs = sync.hsync;
	end

	task automatic make_random_scene(output scene_t sc);
		logic [31:0] r;
		r = $random(seed);
		sc.player_x = game_x_t'(r[15:0] % 640);
		sc.player_y = game_y_t'(r[31:16] % 480);
		r = $random(seed);
		sc.shot_x = game_x_t'(r[15:0] % 640);
		sc.shot_y = game_y_t'(r[31:16] % 480);
		sc.enemy_alive = r[6:0] ^ r[22:16];
		for (int i = 0; i < `ENEMY_COUNT; i++) begin
			r = $random(seed);
			sc.enemy_shot_y[i] = game_y_t'(r[15:0] % 480);
		end
	endtask

	task automatic start_test();
		test_base = errors;
	endtask

	task automatic finish_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, errors - test_base);
	endtask

	// new scene loads at the end of the current frame and runs for one frame
	task automatic show_scene(input scene_t sc);
		@(posedge dclk);
		#1 scene = sc;
		@(frame_start);
		@(frame_start);
	endtask

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------
	initial begin
		dclk = 1'b0;
		clr = 1'b1;
		scene = '0;
		held = '0;
		seed = 32'h9829_32d7;
		locked = 1'b0;
		prev_hs = 1'b1;
		{h, v, hs_low, vs_low, lines, checks, errors, test_base} = '0;

		start_test();
		for (int i = 0; i < 8; i++) begin
			@(negedge dclk);
			check_rgb(rgb, '0);
			check_sync(sync, '1);
		end
		@(posedge dclk);
		#1 clr = 1'b0;
		@(negedge dclk);
		check_rgb(rgb, '0);
		check_sync(sync, '1);
		finish_test(1, "reset state");

		start_test();
		@(frame_start);
		@(frame_start);
		check_count("hsync falling edge", last_lines, `V_TOTAL);
		check_count("hsync low cycle", last_hs_low, `V_TOTAL * `H_PULSE);
		check_count("vsync low cycle", last_vs_low, `V_PULSE * `H_TOTAL);
		finish_test(2, "sync timing");

		start_test();
		make_random_scene(s);
		show_scene(s);
		finish_test(3, "rendered frame");

		start_test();
		s = '0;
		s.enemy_alive = '1;
		for (int i = 0; i < `ENEMY_COUNT; i++) s.enemy_shot_y[i] = game_y_t'(100);
		// player partly over the shot of enemy 0 and player shot over enemy 1
		s.player_x = game_x_t'(`ENEMY_X0 + 4);
		s.player_y = game_y_t'(102);
		s.shot_x = game_x_t'(`ENEMY_X1 + 3);
		s.shot_y = game_y_t'(`ENEMY_ROW0_Y - 4);
		show_scene(s);
		finish_test(4, "layer priority");

		start_test();
		make_random_scene(s);
		@(posedge dclk);
		#1 scene = s;
		@(frame_start);
		repeat (240 * `H_TOTAL) @(posedge dclk);
		make_random_scene(s);
		#1 scene = s;
		@(frame_start);
		@(frame_start);
		finish_test(5, "frame-held scene");

		start_test();
		s = '0;
		s.enemy_alive = 7'b1010101;
		for (int i = 0; i < `ENEMY_COUNT; i++) s.enemy_shot_y[i] = game_y_t'(300);
		// player hangs off the right edge into the blanking
		s.player_x = game_x_t'(636);
		s.player_y = game_y_t'(30);
		s.shot_x = game_x_t'(40);
		s.shot_y = game_y_t'(240);
		show_scene(s);
		finish_test(6, "dead enemies");

		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before the tests reached their end",
			WATCHDOG_NS);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verilog
verilog/vga_pkg.sv
verilog/game_pkg.sv
verilog/raster_timing.sv
verilog/object_hit.sv
verilog/pixel_out.sv
verilog/shooter_display.sv
dv/tb_shooter_display.sv

// File: Bender.yml
package:
  name: shooter_display

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/vga_pkg.sv
      - verilog/game_pkg.sv
      - verilog/raster_timing.sv
      - verilog/object_hit.sv
      - verilog/pixel_out.sv
      - verilog/shooter_display.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/tb_shooter_display.sv
